// File: src/alu_pkg.sv
// Shared types for the ALU subsystem; every RTL block imports what it needs from here.
`default_nettype none

package alu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [3:0]  aluf_t;

   // 0: F, 1: F << 1, 2: carry-out into bit 31 of F >> 1, 3: carry-out into bit 0 of F << 1.
   typedef logic [1:0]  osel_t;

   // IR fields used by the ALU control, listed from the highest IR bit down.
   typedef struct packed {
      osel_t osel;     // IR 13:12
      logic  arith_n;  // IR 7
      logic  first;    // IR 6
      logic  corr;     // IR 5
      logic  f2;       // IR 4
      logic  f3;       // IR 3
      logic  cin;      // IR 2
   } ir_word_t;

   typedef struct packed {
      aluf_t aluf;
      logic  alumode;
      logic  cin0;
   } alu_ctl_t;

   typedef struct packed {
      logic     iralu;
      logic     irjump;
      logic     mul;
      logic     div;
      ir_word_t ir;
   } step_t;

   typedef struct packed {
      logic  load_m;
      logic  load_q;
      word_t data;
   } load_t;

   typedef enum logic [1:0] {
      CMD_ALU  = 2'd0,
      CMD_JUMP = 2'd1,
      CMD_MUL  = 2'd2,
      CMD_DIV  = 2'd3
   } cmd_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_ALU,
      S_MUL,
      S_DIV,
      S_CORR
   } seq_state_t;

endpackage

`default_nettype wire

// File: src/alu_slice.sv
// One 4-bit 74181-style function slice; alu_word tiles these and feeds carries from lookahead.
`timescale 1ns/1ps
`default_nettype none

module alu_slice (
   input  logic [3:0]     a,
   input  logic [3:0]     m,
   input  alu_pkg::aluf_t s,
   input  logic           mode,
   input  logic           cin_n,
   output logic [3:0]     f,
   output logic           x,
   output logic           y
);

   logic [3:0] p;
   logic [3:0] g;
   logic [3:0] c;

   // M is on the chip's A pins, the a bus on its B pins.
   assign p = m | (a & {4{s[0]}}) | (~a & {4{s[1]}});
   assign g = (m & ~a & {4{s[2]}}) | (m & a & {4{s[3]}});

   always_comb begin
      c[0] = ~cin_n;
      for (int i = 1; i < 4; i++) begin
         c[i] = g[i-1] | (p[i-1] & c[i-1]);
      end
   end

   // Logic mode ignores the internal carries entirely.
   assign f = mode ? ~(p & ~g) : ((p & ~g) ^ c);

   // Group terms are active low, as on the real part.
   assign x = ~&p;
   assign y = ~(g[3] |
                (p[3] & g[2]) |
                (p[3] & p[2] & g[1]) |
                (p[3] & p[2] & p[1] & g[0]));

endmodule

`default_nettype wire

// File: src/carry_lookahead.sv
// 74182-style carry lookahead over four groups; used at both levels of the ALU carry tree.
`timescale 1ns/1ps
`default_nettype none

module carry_lookahead (
   input  logic [3:0] x,
   input  logic [3:0] y,
   input  logic       cin_n,
   output logic [2:0] cout_n,
   output logic       xout,
   output logic       yout
);

   // All terms are active low, so each carry is an AND of OR terms.
   assign cout_n[0] = y[0] & (x[0] | cin_n);

   assign cout_n[1] = y[1] & (x[1] | y[0]) & (x[1] | x[0] | cin_n);

   assign cout_n[2] = y[2] & (x[2] | y[1]) & (x[2] | x[1] | y[0]) &
                      (x[2] | x[1] | x[0] | cin_n);

   assign xout = |x;

   assign yout = y[3] & (x[3] | y[2]) & (x[3] | x[2] | y[1]) &
                 (x[3] | x[2] | x[1] | y[0]);

endmodule

`default_nettype wire

// File: src/alu_word.sv
// Full-width ALU built from 74181-style slices and a two-level 74182-style carry tree.
`timescale 1ns/1ps
`default_nettype none

module alu_word #(
   parameter int WIDTH = 32
) (
   input  alu_pkg::word_t    a,
   input  alu_pkg::word_t    m,
   input  alu_pkg::alu_ctl_t ctl,
   output alu_pkg::word_t    f,
   output logic              cout
);

   localparam int NSLICE = WIDTH / 4;
   // One first-level unit per 16 bits; the single top unit limits this to four.
   localparam int NGRP   = WIDTH / 16;

   logic [NSLICE-1:0] sx;
   logic [NSLICE-1:0] sy;
   logic [NSLICE-1:0] scin_n;
   logic [3:0]        gx;
   logic [3:0]        gy;
   logic [4:0]        gcin_n;
   logic              top_x;
   logic              top_y;

   assign gcin_n[0] = ~ctl.cin0;

   for (genvar i = 0; i < NSLICE; i++) begin : g_slice
      alu_slice u_slice (
         .a     (a[4*i +: 4]),
         .m     (m[4*i +: 4]),
         .s     (ctl.aluf),
         .mode  (ctl.alumode),
         .cin_n (scin_n[i]),
         .f     (f[4*i +: 4]),
         .x     (sx[i]),
         .y     (sy[i])
      );
   end

   for (genvar k = 0; k < NGRP; k++) begin : g_group
      carry_lookahead u_cla (
         .x      (sx[4*k +: 4]),
         .y      (sy[4*k +: 4]),
         .cin_n  (gcin_n[k]),
         .cout_n (scin_n[4*k+1 +: 3]),
         .xout   (gx[k]),
         .yout   (gy[k])
      );
      assign scin_n[4*k] = gcin_n[k];
   end

   // Unused top-level inputs neither propagate nor generate.
   for (genvar k = NGRP; k < 4; k++) begin : g_pad
      assign gx[k] = 1'b1;
      assign gy[k] = 1'b1;
   end

   carry_lookahead u_cla_top (
      .x      (gx),
      .y      (gy),
      .cin_n  (gcin_n[0]),
      .cout_n (gcin_n[3:1]),
      .xout   (top_x),
      .yout   (top_y)
   );

   assign gcin_n[4] = top_y & (top_x | gcin_n[0]);

   // Logic mode performs no sum, so no carry leaves the word.
   assign cout = ~ctl.alumode & ~gcin_n[NGRP];

endmodule

`default_nettype wire

// File: src/alu_control.sv
// ALU carry and function control: maps IR bits and step flags onto the slice controls.
`timescale 1ns/1ps
`default_nettype none

module alu_control (
   input  alu_pkg::step_t    step,
   input  logic              a_sign,
   input  logic              q0,
   output alu_pkg::alu_ctl_t ctl,
   output alu_pkg::osel_t    osel
);

   logic last_pos;
   logic sub_cond;
   logic add_cond;
   logic mul_nop;
   logic alu_add;
   logic alu_sub;

   // Q bit 0 records whether the previous divide step left a non-negative remainder.
   assign last_pos = q0 | step.ir.first;
   assign sub_cond = step.div & last_pos;
   assign add_cond = step.div & (step.ir.corr | ~last_pos);
   assign mul_nop  = step.mul & ~q0;

   assign alu_add = step.mul |
                    (add_cond & ~a_sign) |
                    (sub_cond & a_sign);

   assign alu_sub = mul_nop |
                    (sub_cond & ~a_sign) |
                    (add_cond & a_sign) |
                    step.irjump;

   always_comb begin
      case ({alu_sub, alu_add})
         2'b01:   ctl = '{aluf: 4'b1001, alumode: 1'b0, cin0: 1'b0};
         2'b10:   ctl = '{aluf: 4'b0110, alumode: 1'b0, cin0: ~step.irjump};
         2'b11:   ctl = '{aluf: 4'b1111, alumode: 1'b1, cin0: 1'b1};
         default: ctl = '{aluf:    {step.ir.f3, step.ir.f2, ~step.ir.first, ~step.ir.corr},
                          alumode: ~step.ir.arith_n,
                          cin0:    step.ir.cin};
      endcase
   end

   assign osel = step.iralu ? step.ir.osel : 2'b00;

endmodule

`default_nettype wire

// File: src/muldiv_sequencer.sv
// Command sequencer: owns the accumulator and Q and steps the ALU through each command.
`timescale 1ns/1ps
`default_nettype none

module muldiv_sequencer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               start,
   input  alu_pkg::cmd_t      cmd,
   input  alu_pkg::ir_word_t  ir,
   input  alu_pkg::load_t     load,
   input  alu_pkg::osel_t     osel,
   input  alu_pkg::word_t     f,
   input  logic               cout,
   output alu_pkg::step_t     step,
   output alu_pkg::word_t     m_bus,
   output alu_pkg::word_t     acc,
   output alu_pkg::word_t     q,
   output alu_pkg::word_t     result,
   output logic               carry,
   output logic               busy
);

   import alu_pkg::*;

   localparam int LAST_STEP = 31;

   seq_state_t state;
   cmd_t       op;
   logic [4:0] count;
   word_t      f_sel;

   always_comb begin
      step        = '0;
      step.iralu  = (state == S_ALU) && (op == CMD_ALU);
      step.irjump = (state == S_ALU) && (op == CMD_JUMP);
      step.mul    = (state == S_MUL);
      step.div    = (state == S_DIV) || (state == S_CORR);
      if (step.iralu) begin
         step.ir = ir;
      end
      step.ir.first = step.ir.first | ((state == S_DIV) && (count == 5'd0));
      step.ir.corr  = step.ir.corr | (state == S_CORR);
   end

   // Divide steps see the accumulator shifted left with the top of Q entering.
   assign m_bus = (state == S_DIV) ? {acc[30:0], q[31]} : acc;

   always_comb begin
      case (osel)
         2'd1:    f_sel = {f[30:0], 1'b0};
         2'd2:    f_sel = {cout, f[31:1]};
         2'd3:    f_sel = {f[30:0], cout};
         default: f_sel = f;
      endcase
   end

   assign busy = (state != S_IDLE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= S_IDLE;
         op     <= CMD_ALU;
         count  <= '0;
         acc    <= '0;
         q      <= '0;
         result <= '0;
         carry  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (load.load_m) acc <= load.data;
               if (load.load_q) q <= load.data;
               if (start) begin
                  op    <= cmd;
                  count <= '0;
                  case (cmd)
                     CMD_MUL: state <= S_MUL;
                     CMD_DIV: state <= S_DIV;
                     default: state <= S_ALU;
                  endcase
               end
            end
            S_ALU: begin
               carry <= cout;
               if (op == CMD_ALU) result <= f_sel;
               state <= S_IDLE;
            end
            S_MUL: begin
               acc   <= {cout, f[31:1]};
               q     <= {f[0], q[31:1]};
               count <= count + 5'd1;
               if (count == 5'(LAST_STEP)) state <= S_IDLE;
            end
            S_DIV: begin
               acc   <= f;
               q     <= {q[30:0], ~f[31]};
               count <= count + 5'd1;
               if (count == 5'(LAST_STEP)) state <= S_CORR;
            end
            S_CORR: begin
               // Adds the divisor back only when the last remainder went negative.
               acc   <= f;
               state <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/alu_regs.sv
// Wishbone classic register block holding operands, IR and command for the sequencer.
`timescale 1ns/1ps
`default_nettype none

module alu_regs (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  logic [2:0]         adr,
   input  alu_pkg::word_t     dat_w,
   output alu_pkg::word_t     dat_r,
   output logic               ack,
   input  logic               busy,
   input  alu_pkg::word_t     acc,
   input  alu_pkg::word_t     q,
   input  alu_pkg::word_t     result,
   input  logic               carry,
   output alu_pkg::word_t     operand_a,
   output alu_pkg::ir_word_t  ir,
   output alu_pkg::load_t     load,
   output logic               start,
   output alu_pkg::cmd_t      cmd
);

   import alu_pkg::*;

   localparam logic [2:0] ADR_A      = 3'd0;
   localparam logic [2:0] ADR_M      = 3'd1;
   localparam logic [2:0] ADR_Q      = 3'd2;
   localparam logic [2:0] ADR_IR     = 3'd3;
   localparam logic [2:0] ADR_CMD    = 3'd4;
   localparam logic [2:0] ADR_STATUS = 3'd5;
   localparam logic [2:0] ADR_RESULT = 3'd6;

   logic  req;
   logic  wr;
   word_t ir_reg;
   word_t rd_mux;

   // A request is served once; ack itself closes it off for the next edge.
   assign req = cyc & stb & ~ack;
   assign wr  = req & we;

   assign load.load_m = wr && (adr == ADR_M) && !busy;
   assign load.load_q = wr && (adr == ADR_Q) && !busy;
   assign load.data   = dat_w;

   assign ir = '{osel:    ir_reg[13:12],
                 arith_n: ir_reg[7],
                 first:   ir_reg[6],
                 corr:    ir_reg[5],
                 f2:      ir_reg[4],
                 f3:      ir_reg[3],
                 cin:     ir_reg[2]};

   always_comb begin
      case (adr)
         ADR_A:      rd_mux = operand_a;
         ADR_M:      rd_mux = acc;
         ADR_Q:      rd_mux = q;
         ADR_IR:     rd_mux = ir_reg;
         ADR_STATUS: rd_mux = {30'd0, carry, busy};
         ADR_RESULT: rd_mux = result;
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack       <= 1'b0;
         dat_r     <= '0;
         operand_a <= '0;
         ir_reg    <= '0;
         start     <= 1'b0;
         cmd       <= CMD_ALU;
      end else begin
         ack   <= req;
         start <= wr && (adr == ADR_CMD) && !busy;
         if (req && !we) dat_r <= rd_mux;
         if (wr && adr == ADR_A) operand_a <= dat_w;
         if (wr && adr == ADR_IR) ir_reg <= dat_w;
         if (wr && adr == ADR_CMD && !busy) cmd <= cmd_t'(dat_w[1:0]);
      end
   end

endmodule

`default_nettype wire

// File: src/alu_unit_top.sv
// Top level of the ALU subsystem; a host drives it over Wishbone classic.
`timescale 1ns/1ps
`default_nettype none

module alu_unit_top (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           cyc,
   input  logic           stb,
   input  logic           we,
   input  logic [2:0]     adr,
   input  alu_pkg::word_t dat_w,
   output alu_pkg::word_t dat_r,
   output logic           ack
);

   import alu_pkg::*;

   word_t    operand_a;
   ir_word_t ir;
   load_t    load;
   logic     start;
   cmd_t     cmd;
   step_t    step;
   word_t    m_bus;
   word_t    acc;
   word_t    q;
   word_t    result;
   logic     carry;
   logic     busy;
   alu_ctl_t ctl;
   osel_t    osel;
   word_t    f;
   logic     cout;

   alu_regs u_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .dat_r     (dat_r),
      .ack       (ack),
      .busy      (busy),
      .acc       (acc),
      .q         (q),
      .result    (result),
      .carry     (carry),
      .operand_a (operand_a),
      .ir        (ir),
      .load      (load),
      .start     (start),
      .cmd       (cmd)
   );

   muldiv_sequencer u_seq (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (start),
      .cmd    (cmd),
      .ir     (ir),
      .load   (load),
      .osel   (osel),
      .f      (f),
      .cout   (cout),
      .step   (step),
      .m_bus  (m_bus),
      .acc    (acc),
      .q      (q),
      .result (result),
      .carry  (carry),
      .busy   (busy)
   );

   alu_control u_ctl (
      .step   (step),
      .a_sign (operand_a[31]),
      .q0     (q[0]),
      .ctl    (ctl),
      .osel   (osel)
   );

   alu_word #(
      .WIDTH (32)
   ) u_alu (
      .a    (operand_a),
      .m    (m_bus),
      .ctl  (ctl),
      .f    (f),
      .cout (cout)
   );

endmodule

`default_nettype wire

// File: tests/alu_unit_checker.sv
// Bus and busy protocol assertions, bound into the ALU subsystem top level.
`timescale 1ns/1ps
`default_nettype none

module alu_unit_checker (
   input logic       clk,
   input logic       rst_n,
   input logic       cyc,
   input logic       stb,
   input logic       we,
   input logic [2:0] adr,
   input logic       ack,
   input logic       busy
);

   ack_in_request: assert property (@(posedge clk) disable iff (!rst_n)
      ack |-> (cyc && stb))
      else $error("ack is high outside a bus request");

   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack |=> !ack)
      else $error("ack stayed high for two cycles");

   // Busy rises one cycle after the acknowledged command write.
   busy_after_command: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(busy) |-> $past(ack && we && (adr == 3'd4)))
      else $error("busy rose without a command write");

endmodule

bind alu_unit_top alu_unit_checker u_checker (
   .clk   (clk),
   .rst_n (rst_n),
   .cyc   (cyc),
   .stb   (stb),
   .we    (we),
   .adr   (adr),
   .ack   (ack),
   .busy  (busy)
);

`default_nettype wire

// File: tests/alu_unit_tb.sv
// Directed testbench for the ALU subsystem; drives the Wishbone port and checks every command.
`timescale 1ns/1ps
`default_nettype none

module alu_unit_tb;

   import alu_pkg::*;

   localparam int RESET_CYCLES = 10;
   // The directed tests need roughly 2000 cycles; this leaves a wide margin.
   localparam int TIMEOUT_CYCLES = 20000;

   logic       clk;
   logic       rst_n;
   logic       cyc;
   logic       stb;
   logic       we;
   logic [2:0] adr;
   word_t      dat_w;
   word_t      dat_r;
   logic       ack;
   integer     seed;
   int         cycles = 0;

   alu_unit_top u_dut (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $fatal(1);
      end
   end

   task automatic check_word(input string name, input word_t got, input word_t exp);
      assert (got == exp) else begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // Ack is sampled on the falling edge, away from the edge that moves it.
   task automatic await_ack;
      @(negedge clk);
      while (!ack) @(negedge clk);
   endtask

   task automatic release_bus;
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   task automatic bus_write(input logic [2:0] addr, input word_t data);
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= addr;
      dat_w <= data;
      await_ack();
      release_bus();
   endtask

   task automatic bus_read(input logic [2:0] addr, output word_t data);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= addr;
      await_ack();
      data = dat_r;
      release_bus();
   endtask

   task automatic wait_idle;
      word_t status;
      bus_read(3'd5, status);
      while (status[0]) begin
         bus_read(3'd5, status);
      end
   endtask

   task automatic run_command(input cmd_t c);
      bus_write(3'd4, {30'd0, c});
      wait_idle();
   endtask

   // Operations: 0 add, 1 add with carry-in, 2 subtract, 3 pass, 4 and, 5 or, 6 xor.
   function automatic word_t ir_for_op(input int op, input logic [1:0] sel);
      logic [4:0] fld;
      logic       cin;
      case (op)
         0, 1:    fld = 5'b11001;
         2:       fld = 5'b10110;
         3:       fld = 5'b00011;
         4:       fld = 5'b00001;
         5:       fld = 5'b00111;
         default: fld = 5'b00110;
      endcase
      cin = (op == 1) || (op == 2);
      // Fields from the top: arith_n, first, corr, f2, f3, then cin at bit 2.
      return {18'd0, sel, 4'd0, fld, cin, 2'd0};
   endfunction

   function automatic void model_alu(input int op, input word_t m, input word_t a,
                                     input logic [1:0] sel, output word_t res,
                                     output logic carry);
      logic [32:0] sum;
      word_t       f;
      case (op)
         0:       sum = {1'b0, m} + {1'b0, a};
         1:       sum = {1'b0, m} + {1'b0, a} + 33'd1;
         2:       sum = {1'b0, m} + {1'b0, ~a} + 33'd1;
         default: sum = 33'd0;
      endcase
      case (op)
         3:       f = m;
         4:       f = m & a;
         5:       f = m | a;
         6:       f = m ^ a;
         default: f = sum[31:0];
      endcase
      // Logic mode forms no sum, so its carry stays clear.
      carry = sum[32];
      case (sel)
         2'd1:    res = {f[30:0], 1'b0};
         2'd2:    res = {carry, f[31:1]};
         2'd3:    res = {f[30:0], carry};
         default: res = f;
      endcase
   endfunction

   task automatic test_registers;
      word_t val[4];
      word_t rd;
      for (int i = 0; i < 7; i++) begin
         bus_read(i[2:0], rd);
         check_word("reset value", rd, 32'd0);
      end
      for (int i = 0; i < 4; i++) begin
         val[i] = $random(seed);
         bus_write(i[2:0], val[i]);
      end
      for (int i = 0; i < 4; i++) begin
         bus_read(i[2:0], rd);
         check_word("register readback", rd, val[i]);
      end
      bus_read(3'd4, rd);
      check_word("command readback", rd, 32'd0);
   endtask

   task automatic test_alu_ops;
      word_t m;
      word_t a;
      word_t rd;
      word_t exp_res;
      logic  exp_carry;
      for (int op = 0; op < 7; op++) begin
         for (int sel = 0; sel < 4; sel++) begin
            m = $random(seed);
            a = $random(seed);
            bus_write(3'd1, m);
            bus_write(3'd0, a);
            bus_write(3'd3, ir_for_op(op, sel[1:0]));
            run_command(CMD_ALU);
            model_alu(op, m, a, sel[1:0], exp_res, exp_carry);
            bus_read(3'd6, rd);
            check_word("result", rd, exp_res);
            bus_read(3'd5, rd);
            check_word("status carry", {31'd0, rd[1]}, {31'd0, exp_carry});
         end
      end
   endtask

   task automatic test_jump;
      word_t m;
      word_t a;
      word_t rd;
      for (int i = 0; i < 16; i++) begin
         m = $random(seed);
         a = $random(seed);
         if (i == 0) a = m;
         if (i == 1) a = m - 32'd1;
         bus_write(3'd1, m);
         bus_write(3'd0, a);
         run_command(CMD_JUMP);
         bus_read(3'd5, rd);
         check_word("jump carry", {31'd0, rd[1]}, {31'd0, m > a});
      end
   endtask

   task automatic multiply_check(input word_t a, input word_t qv, input logic busy_writes);
      logic [63:0] prod;
      word_t       rd;
      bus_write(3'd0, a);
      bus_write(3'd1, 32'd0);
      bus_write(3'd2, qv);
      bus_write(3'd4, {30'd0, CMD_MUL});
      if (busy_writes) begin
         bus_write(3'd4, {30'd0, CMD_DIV});
         bus_write(3'd1, $random(seed));
         bus_write(3'd2, $random(seed));
      end
      wait_idle();
      prod = {32'd0, a} * {32'd0, qv};
      bus_read(3'd1, rd);
      check_word("product high (M)", rd, prod[63:32]);
      bus_read(3'd2, rd);
      check_word("product low (Q)", rd, prod[31:0]);
   endtask

   task automatic test_multiply;
      for (int i = 0; i < 8; i++) begin
         multiply_check($random(seed), $random(seed), 1'b0);
      end
   endtask

   task automatic test_divide;
      word_t divisor;
      word_t dividend;
      word_t rd;
      int    sh;
      for (int i = 0; i < 8; i++) begin
         sh       = $random(seed) & 31;
         divisor  = ($random(seed) & 32'h7FFF_FFFF) >> sh;
         dividend = $random(seed);
         if (divisor == 32'd0) divisor = 32'd1;
         bus_write(3'd0, divisor);
         bus_write(3'd1, 32'd0);
         bus_write(3'd2, dividend);
         run_command(CMD_DIV);
         bus_read(3'd2, rd);
         check_word("quotient (Q)", rd, dividend / divisor);
         bus_read(3'd1, rd);
         check_word("remainder (M)", rd, dividend % divisor);
      end
   endtask

   task automatic test_busy_writes;
      multiply_check($random(seed), $random(seed), 1'b1);
   endtask

   initial begin
      seed  = 82620;
      clk   = 1'b0;
      rst_n = 1'b0;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = 3'd0;
      dat_w = 32'd0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      test_registers();
      test_alu_ops();
      test_jump();
      test_multiply();
      test_divide();
      test_busy_writes();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
src/alu_pkg.sv
src/alu_slice.sv
src/carry_lookahead.sv
src/alu_word.sv
src/alu_control.sv
src/muldiv_sequencer.sv
src/alu_regs.sv
src/alu_unit_top.sv
tests/alu_unit_checker.sv
tests/alu_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ALU subsystem testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
PASS_TEXT="Simulation completed successfully"

verilator --binary --timing --assert --top-module alu_unit_tb \
   --Mdir "$BUILD_DIR" -o alu_unit_sim -f files.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/alu_unit_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi

if grep -q "$PASS_TEXT" "$LOG_FILE"; then
   exit 0
else
   exit 1
fi
